// ==== logic/afu_ctrl_pkg.sv ====
package afu_ctrl_pkg;

    localparam int ctrl_addr_w = 4;
    localparam int ctrl_data_w = 32;

    localparam logic [ctrl_addr_w-1:0] reg_ap_ctrl  = 4'd0;
    localparam logic [ctrl_addr_w-1:0] reg_gie      = 4'd1;
    localparam logic [ctrl_addr_w-1:0] reg_ier      = 4'd2;
    localparam logic [ctrl_addr_w-1:0] reg_isr      = 4'd3;
    localparam logic [ctrl_addr_w-1:0] reg_cfg_base = 4'd8;
    localparam logic [ctrl_addr_w-1:0] num_cfg_regs = 4'd3;

    // AP_CTRL bit positions.
    localparam int bit_start      = 0;
    localparam int bit_done       = 1;
    localparam int bit_idle       = 2;
    localparam int bit_ready      = 3;
    localparam int bit_soft_reset = 4;

    localparam int reset_delay = 8;
    localparam int delay_cnt_w = $clog2(reset_delay);

    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [ctrl_addr_w-1:0] addr;
        logic [ctrl_data_w-1:0] data;
    } ctrl_req_t;

    typedef struct packed {
        logic                   valid;
        logic [ctrl_data_w-1:0] data;
    } ctrl_rsp_t;

    typedef struct packed {
        logic                   valid;
        logic [1:0]             num;  // Engine register number.
        logic [ctrl_data_w-1:0] data;
    } cfg_wr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_reset_wait,
        st_busy_wait,
        st_running
    } seq_state_t;

endpackage

// ==== logic/afu_mem_pkg.sv ====
package afu_mem_pkg;

    localparam int mem_addr_w = 32;
    localparam int mem_data_w = 32;
    localparam int pending_w  = 8;

    // Fill engine configuration registers.
    localparam logic [1:0] cfg_base  = 2'd0;
    localparam logic [1:0] cfg_count = 2'd1;
    localparam logic [1:0] cfg_seed  = 2'd2;

    typedef struct packed {
        logic                  valid;
        logic [mem_addr_w-1:0] addr;
        logic [mem_data_w-1:0] data;
    } mem_wr_req_t;

endpackage

// ==== logic/afu_control.sv ====
module afu_control import afu_ctrl_pkg::*; (
    input  logic      ap_clk,
    input  logic      reset,
    input  ctrl_req_t ctrl_req,
    output ctrl_rsp_t ctrl_rsp,
    input  logic      idle,
    input  logic      done_level,
    output logic      start_pulse,
    output logic      soft_reset,
    output cfg_wr_t   cfg_wr,
    output logic      interrupt
);

    logic                   ap_ctrl_wr;
    logic                   ap_ctrl_rd;
    logic [ctrl_addr_w-1:0] cfg_off;
    logic                   done;
    logic                   done_level_q;
    logic                   done_edge;
    logic                   gie;
    logic                   ier;
    logic                   isr;
    logic                   rsp_valid;
    logic [ctrl_data_w-1:0] rsp_data;
    logic [ctrl_data_w-1:0] rd_data;

    assign ap_ctrl_wr = ctrl_req.wr && (ctrl_req.addr == reg_ap_ctrl);
    assign ap_ctrl_rd = ctrl_req.rd && (ctrl_req.addr == reg_ap_ctrl);

    assign start_pulse = ap_ctrl_wr && ctrl_req.data[bit_start] && idle;  // Ignored when busy.
    assign soft_reset  = ap_ctrl_wr && ctrl_req.data[bit_soft_reset];
    assign done_edge   = done_level && !done_level_q;

    // Addresses below the base wrap to large offsets and fail the range check.
    assign cfg_off = ctrl_req.addr - reg_cfg_base;
    assign cfg_wr  = '{valid: ctrl_req.wr && (cfg_off < num_cfg_regs),
                       num:   cfg_off[1:0],
                       data:  ctrl_req.data};

    assign interrupt = gie && ier && isr;
    assign ctrl_rsp  = '{valid: rsp_valid, data: rsp_data};

    always_comb begin
        rd_data = '0;
        case (ctrl_req.addr)
            reg_ap_ctrl: begin
                rd_data[bit_start] = !idle;
                rd_data[bit_done]  = done;
                rd_data[bit_idle]  = idle;
                rd_data[bit_ready] = 1'b1;
            end
            reg_gie: rd_data[0] = gie;
            reg_ier: rd_data[0] = ier;
            reg_isr: rd_data[0] = isr;
            default: ;  // Config registers read as zero.
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            gie <= 1'b0;
            ier <= 1'b0;
        end else if (ctrl_req.wr) begin
            if (ctrl_req.addr == reg_gie) gie <= ctrl_req.data[0];
            if (ctrl_req.addr == reg_ier) ier <= ctrl_req.data[0];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (reset || soft_reset) begin
            done         <= 1'b0;
            isr          <= 1'b0;
            done_level_q <= 1'b1;  // No edge right after reset.
            rsp_valid    <= 1'b0;
        end else begin
            done_level_q <= done_level;
            rsp_valid    <= ctrl_req.rd;
            if (done_edge) begin
                done <= 1'b1;
            end else if (ap_ctrl_rd) begin
                done <= 1'b0;  // Clear on read.
            end
            if (ctrl_req.wr && (ctrl_req.addr == reg_isr)) begin
                isr <= (isr ^ ctrl_req.data[0]) | done_edge;
            end else if (done_edge) begin
                isr <= 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (ctrl_req.rd) rsp_data <= rd_data;
    end

endmodule

// ==== logic/afu_sequencer.sv ====
module afu_sequencer import afu_ctrl_pkg::*; (
    input  logic ap_clk,
    input  logic reset,
    input  logic soft_reset,
    input  logic start_pulse,
    input  logic delay_expired,
    input  logic engine_busy,
    input  logic pending_zero,
    output logic core_run,
    output logic reset_wait,
    output logic idle,
    output logic done_level
);

    seq_state_t state;

    always_ff @(posedge ap_clk) begin
        if (reset || soft_reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start_pulse) state <= st_reset_wait;
                end
                st_reset_wait: begin
                    if (delay_expired) state <= st_busy_wait;  // Core leaves reset.
                end
                st_busy_wait: begin
                    if (engine_busy) state <= st_running;
                end
                st_running: begin
                    if (!engine_busy) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign core_run   = (state == st_busy_wait) || (state == st_running);
    assign reset_wait = (state == st_reset_wait);
    assign idle       = (state == st_idle);

    // Writes still in flight hold done off.
    assign done_level = idle && pending_zero;

endmodule

// ==== logic/afu_counters.sv ====
module afu_counters import afu_ctrl_pkg::*, afu_mem_pkg::*; (
    input  logic ap_clk,
    input  logic reset,
    input  logic soft_reset,
    input  logic reset_wait,
    input  logic write_fire,
    input  logic mem_wr_rsp,
    output logic delay_expired,
    output logic pending_zero
);

    logic [delay_cnt_w-1:0] delay_cnt;
    logic [pending_w-1:0]   pending;

    always_ff @(posedge ap_clk) begin
        if (reset || soft_reset || !reset_wait) begin
            delay_cnt <= '0;
        end else begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    assign delay_expired = reset_wait && (delay_cnt == delay_cnt_w'(reset_delay - 1));

    always_ff @(posedge ap_clk) begin
        if (reset || soft_reset) begin
            pending <= '0;
        end else if (write_fire && !mem_wr_rsp) begin
            pending <= pending + 1'b1;
        end else if (!write_fire && mem_wr_rsp && (pending != '0)) begin
            pending <= pending - 1'b1;  // Late responses after an abort are dropped.
        end
    end

    assign pending_zero = (pending == '0);

endmodule

// ==== logic/fill_engine.sv ====
module fill_engine import afu_ctrl_pkg::*, afu_mem_pkg::*; (
    input  logic        ap_clk,
    input  logic        reset,
    input  logic        run,
    input  cfg_wr_t     cfg_wr,
    output mem_wr_req_t mem_wr_req,
    input  logic        mem_wr_ready,
    output logic        busy
);

    logic [mem_addr_w-1:0] base;
    logic [mem_data_w-1:0] count;
    logic [mem_data_w-1:0] seed;
    logic [mem_data_w-1:0] idx;
    logic                  req_valid;
    logic                  started;
    logic                  last;

    assign last = (idx == count - 1'b1);

    always_ff @(posedge ap_clk) begin
        if (reset) begin
            base  <= '0;
            count <= '0;
            seed  <= '0;
        end else if (cfg_wr.valid) begin
            case (cfg_wr.num)
                cfg_base:  base  <= cfg_wr.data;
                cfg_count: count <= cfg_wr.data;
                cfg_seed:  seed  <= cfg_wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (!run) begin
            busy      <= 1'b0;
            started   <= 1'b0;
            req_valid <= 1'b0;
        end else if (!started) begin
            started   <= 1'b1;  // One pass per release.
            busy      <= 1'b1;
            req_valid <= (count != '0);
            idx       <= '0;
        end else if (busy) begin
            if (!req_valid) begin
                busy <= 1'b0;  // Zero count.
            end else if (mem_wr_ready) begin
                if (last) begin
                    req_valid <= 1'b0;
                    busy      <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // idx only moves on acceptance, so a stalled request holds.
    assign mem_wr_req = '{valid: req_valid,
                          addr:  base + mem_addr_w'(idx),
                          data:  seed + idx};

endmodule

// ==== logic/afu_top.sv ====
module afu_top import afu_ctrl_pkg::*, afu_mem_pkg::*; (
    input  logic        ap_clk,
    input  logic        reset,
    input  ctrl_req_t   ctrl_req,
    output ctrl_rsp_t   ctrl_rsp,
    output logic        interrupt,
    output mem_wr_req_t mem_wr_req,
    input  logic        mem_wr_ready,
    input  logic        mem_wr_rsp
);

    logic    start_pulse;
    logic    soft_reset;
    cfg_wr_t cfg_wr;
    logic    idle;
    logic    done_level;
    logic    delay_expired;
    logic    engine_busy;
    logic    pending_zero;
    logic    core_run;
    logic    reset_wait;
    logic    engine_reset;
    logic    write_fire;

    assign engine_reset = reset || soft_reset || !core_run;  // Config survives this one.
    assign write_fire   = mem_wr_req.valid && mem_wr_ready;

    afu_control u_control (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .ctrl_req    (ctrl_req),
        .ctrl_rsp    (ctrl_rsp),
        .idle        (idle),
        .done_level  (done_level),
        .start_pulse (start_pulse),
        .soft_reset  (soft_reset),
        .cfg_wr      (cfg_wr),
        .interrupt   (interrupt)
    );

    afu_sequencer u_sequencer (
        .ap_clk        (ap_clk),
        .reset         (reset),
        .soft_reset    (soft_reset),
        .start_pulse   (start_pulse),
        .delay_expired (delay_expired),
        .engine_busy   (engine_busy),
        .pending_zero  (pending_zero),
        .core_run      (core_run),
        .reset_wait    (reset_wait),
        .idle          (idle),
        .done_level    (done_level)
    );

    afu_counters u_counters (
        .ap_clk        (ap_clk),
        .reset         (reset),
        .soft_reset    (soft_reset),
        .reset_wait    (reset_wait),
        .write_fire    (write_fire),
        .mem_wr_rsp    (mem_wr_rsp),
        .delay_expired (delay_expired),
        .pending_zero  (pending_zero)
    );

    fill_engine u_engine (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .run          (!engine_reset),
        .cfg_wr       (cfg_wr),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_ready (mem_wr_ready),
        .busy         (engine_busy)
    );

endmodule

// ==== verif/afu_checker.sv ====
module afu_checker import afu_ctrl_pkg::*, afu_mem_pkg::*; (
    input logic        ap_clk,
    input logic        reset,
    input mem_wr_req_t mem_wr_req,
    input logic        mem_wr_ready,
    input logic        mem_wr_rsp,
    input int          test_num,
    input logic        test_end,
    input int          exp_writes,
    input logic        run_start,
    input logic [31:0] cfg_base,
    input logic [31:0] cfg_seed
);

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int test_errors  = 0;
    int test_writes  = 0;
    int run_writes   = 0;
    int run_rsps     = 0;
    int start_cycle  = 0;
    int cycle        = 0;

    // Write i of a fill lands at base + i and holds seed + i.
    function automatic logic [63:0] expected_write(input logic [31:0] base,
                                                   input logic [31:0] seed, input int i);
        logic [31:0] addr;
        logic [31:0] data;
        addr = base + i;
        data = seed + i;
        return {addr, data};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input string what, input logic ok);
        if (!ok) begin
            $display("check failed at %0t: %s", $time, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic print_counts();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    endtask

    always @(posedge ap_clk) begin
        logic [63:0] exp;
        cycle = cycle + 1;
        if (run_start) begin
            run_writes  = 0;
            run_rsps    = 0;
            start_cycle = cycle;
        end
        if (!reset && mem_wr_rsp) run_rsps++;
        if (!reset && mem_wr_req.valid && mem_wr_ready) begin
            if (run_writes == 0)
                check_true("write issued before the core left reset",
                           (cycle - start_cycle) >= 1 + reset_delay);
            exp = expected_write(cfg_base, cfg_seed, run_writes);
            check_value("write address", mem_wr_req.addr, exp[63:32]);
            check_value("write data", mem_wr_req.data, exp[31:0]);
            run_writes++;
            test_writes++;
        end
        if (test_end) begin
            if (exp_writes >= 0) check_value("write count", test_writes, exp_writes);
            tests_run++;
            if (test_errors == 0) begin
                $display("test %0d passed, %0d writes", test_num, test_writes);
            end else begin
                $display("test %0d failed, %0d errors", test_num, test_errors);
                tests_failed++;
            end
            test_errors = 0;
            test_writes = 0;
        end
    end

endmodule

// ==== verif/afu_asserts.sv ====
module afu_asserts import afu_ctrl_pkg::*, afu_mem_pkg::*; (
    input logic        ap_clk,
    input logic        reset,
    input ctrl_req_t   ctrl_req,
    input mem_wr_req_t mem_wr_req,
    input logic        mem_wr_ready,
    input logic        interrupt,
    input logic        core_run
);

    logic gie_written;

    always @(posedge ap_clk) begin
        if (reset) begin
            gie_written <= 1'b0;
        end else if (ctrl_req.wr && (ctrl_req.addr == reg_gie)) begin
            gie_written <= ctrl_req.data[0];  // GIE as last written by the host.
        end
    end

    // A stalled request keeps its address and data unless it is withdrawn by an abort.
    assert property (@(posedge ap_clk) disable iff (reset)
        (mem_wr_req.valid && !mem_wr_ready) |=>
            (!mem_wr_req.valid || ($stable(mem_wr_req.addr) && $stable(mem_wr_req.data))))
        else $error("write request changed while stalled");

    assert property (@(posedge ap_clk) disable iff (reset) interrupt |-> gie_written)
        else $error("interrupt high with GIE clear");

    assert property (@(posedge ap_clk) disable iff (reset) mem_wr_req.valid |-> core_run)
        else $error("write request while core held in reset");

endmodule

bind afu_top afu_asserts u_asserts (
    .ap_clk       (ap_clk),
    .reset        (reset),
    .ctrl_req     (ctrl_req),
    .mem_wr_req   (mem_wr_req),
    .mem_wr_ready (mem_wr_ready),
    .interrupt    (interrupt),
    .core_run     (core_run)
);

// ==== verif/tb_afu.sv ====
module tb_afu import afu_ctrl_pkg::*, afu_mem_pkg::*; ();

    logic        ap_clk       = 1'b0;
    logic        reset        = 1'b1;
    ctrl_req_t   ctrl_req     = '0;
    ctrl_rsp_t   ctrl_rsp;
    logic        interrupt;
    mem_wr_req_t mem_wr_req;
    logic        mem_wr_ready = 1'b0;
    logic        mem_wr_rsp   = 1'b0;
    int          seed         = 75168;
    int          cycle        = 0;
    int          cur_test     = 0;
    logic        long_delay   = 1'b0;
    logic        flush_rsp    = 1'b0;
    logic        run_start    = 1'b0;
    logic        test_end     = 1'b0;
    int          exp_writes   = 0;
    logic [31:0] cfg_base_v   = '0;
    logic [31:0] cfg_seed_v   = '0;
    int          rsp_due[$];

    always #50 ap_clk = ~ap_clk;

    always @(posedge ap_clk) cycle <= cycle + 1;

    afu_top u_afu_top (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .ctrl_req     (ctrl_req),
        .ctrl_rsp     (ctrl_rsp),
        .interrupt    (interrupt),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_ready (mem_wr_ready),
        .mem_wr_rsp   (mem_wr_rsp)
    );

    afu_checker u_checker (
        .ap_clk       (ap_clk),
        .reset        (reset),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_ready (mem_wr_ready),
        .mem_wr_rsp   (mem_wr_rsp),
        .test_num     (cur_test),
        .test_end     (test_end),
        .exp_writes   (exp_writes),
        .run_start    (run_start),
        .cfg_base     (cfg_base_v),
        .cfg_seed     (cfg_seed_v)
    );

    // Memory model with random ready and one response per accepted write.
    always @(posedge ap_clk) begin
        int delay;
        delay = long_delay ? 30 : {$random(seed)} % 6;
        if (mem_wr_req.valid && mem_wr_ready) rsp_due.push_back(cycle + delay);
        if (flush_rsp) rsp_due.delete();
        #1;
        mem_wr_rsp = 1'b0;
        if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
            mem_wr_rsp = 1'b1;
            void'(rsp_due.pop_front());
        end
        mem_wr_ready = ({$random(seed)} % 4) != 0;
    end

    function automatic int test_cycles(input int n);
        case (n)
            1: return 20;
            2: return 60;
            3: return 90;
            4: return 60;
            5: return 70;
            default: return 30;
        endcase
    endfunction

    initial begin
        int limit;
        limit = 0;
        for (int n = 1; n <= 6; n++) limit += test_cycles(n);
        limit = limit * 40;
        repeat (limit) @(posedge ap_clk);
        $display("timeout: test %0d did not finish within %0d cycles", cur_test, limit);
        $display("Some tests failed");
        $finish;
    end

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(posedge ap_clk);
        #1;
        ctrl_req = '{wr: 1'b1, rd: 1'b0, addr: addr, data: data};
        @(posedge ap_clk);
        #1;
        ctrl_req = '0;
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        @(posedge ap_clk);
        #1;
        ctrl_req = '{wr: 1'b0, rd: 1'b1, addr: addr, data: 32'h0};
        @(posedge ap_clk);
        #1;
        ctrl_req = '0;
        u_checker.check_true("read response valid one cycle after the strobe", ctrl_rsp.valid);
        data = ctrl_rsp.data;
    endtask

    task automatic set_config(input logic [31:0] base, input logic [31:0] count,
                              input logic [31:0] seed_val);
        write_reg(reg_cfg_base, base);
        write_reg(reg_cfg_base + 4'd1, count);
        write_reg(reg_cfg_base + 4'd2, seed_val);
        cfg_base_v = base;
        cfg_seed_v = seed_val;
    endtask

    task automatic start_run();
        @(posedge ap_clk);
        #1;
        ctrl_req  = '{wr: 1'b1, rd: 1'b0, addr: reg_ap_ctrl, data: 32'h1};
        run_start = 1'b1;
        @(posedge ap_clk);
        #1;
        ctrl_req  = '0;
        run_start = 1'b0;
    endtask

    // Polls AP_CTRL; done or interrupt must not show up with writes unanswered.
    task automatic wait_done();
        logic [31:0] v;
        v = '0;
        while (!v[bit_done]) begin
            read_reg(reg_ap_ctrl, v);
            if (v[bit_done] || interrupt)
                u_checker.check_value("responses at done", u_checker.run_rsps,
                                      u_checker.run_writes);
        end
    endtask

    task automatic end_test(input int exp);
        @(posedge ap_clk);
        #1;
        exp_writes = exp;
        test_end   = 1'b1;
        @(posedge ap_clk);
        #1;
        test_end   = 1'b0;
    endtask

    initial begin
        logic [31:0] v;
        int held;
        repeat (4) @(posedge ap_clk);
        #1;
        reset = 1'b0;

        cur_test = 1;  // Register readback.
        write_reg(reg_gie, 32'h1);
        write_reg(reg_ier, 32'h1);
        read_reg(reg_gie, v);
        u_checker.check_value("GIE", v, 32'h1);
        read_reg(reg_ier, v);
        u_checker.check_value("IER", v, 32'h1);
        read_reg(reg_ap_ctrl, v);
        u_checker.check_value("AP_CTRL", v, (32'h1 << bit_idle) | (32'h1 << bit_ready));
        end_test(0);

        cur_test = 2;  // Fill content under back-pressure.
        set_config(32'h100, 32'd20, $random(seed));
        start_run();
        wait_done();
        end_test(20);

        cur_test = 3;
        write_reg(reg_isr, 32'h1);
        long_delay = 1'b1;
        start_run();
        wait_done();
        u_checker.check_value("interrupt after done", interrupt, 1'b1);
        read_reg(reg_ap_ctrl, v);
        u_checker.check_value("done after read", v[bit_done], 1'b0);
        long_delay = 1'b0;
        end_test(20);

        cur_test = 4;
        write_reg(reg_isr, 32'h1);
        u_checker.check_value("interrupt after ISR write", interrupt, 1'b0);
        write_reg(reg_gie, 32'h0);
        start_run();
        wait_done();
        u_checker.check_value("interrupt with GIE clear", interrupt, 1'b0);
        end_test(20);

        cur_test = 5;  // Soft reset abort.
        start_run();
        while (u_checker.run_writes < 5) begin
            @(posedge ap_clk);
            #1;
        end
        flush_rsp = 1'b1;
        write_reg(reg_ap_ctrl, 32'h1 << bit_soft_reset);
        flush_rsp = 1'b0;
        held = u_checker.run_writes;
        repeat (20) @(posedge ap_clk);
        u_checker.check_value("writes after abort", u_checker.run_writes, held);
        read_reg(reg_ap_ctrl, v);
        u_checker.check_value("idle after abort", v[bit_idle], 1'b1);
        write_reg(reg_cfg_base + 4'd1, 32'd3);
        start_run();
        wait_done();
        u_checker.check_value("writes after restart", u_checker.run_writes, 3);
        end_test(-1);

        cur_test = 6;
        write_reg(reg_cfg_base + 4'd1, 32'd0);
        start_run();
        wait_done();
        end_test(0);

        u_checker.print_counts();
        if (u_checker.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/afu_ctrl_pkg.sv
logic/afu_mem_pkg.sv
logic/afu_control.sv
logic/afu_sequencer.sv
logic/afu_counters.sv
logic/fill_engine.sv
logic/afu_top.sv
verif/afu_checker.sv
verif/afu_asserts.sv
verif/tb_afu.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_afu -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_afu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
